// File: hdl/quiz_setup_consts.svh
`ifndef QUIZ_SETUP_CONSTS_SVH
`define QUIZ_SETUP_CONSTS_SVH

// button sampling period in clock cycles
`define TICK_PERIOD     25000000

`define QUESTION_DEPTH  50          // records in the bank
`define NUM_KINDS       5

// operators per kind
`define OPS_KIND_1      3
`define OPS_KIND_2      2
`define OPS_OTHER       4

////////////////////
// glyphs, bits a..g then dot
`define SEG_BLANK       8'b0000_0000
`define SEG_A_PROMPT    8'b0011_1010
`define SEG_B_PROMPT    8'b0011_1110
`define SEG_DIGIT_0     8'b1111_1100
`define SEG_DIGIT_1     8'b0110_0000
`define SEG_DIGIT_2     8'b1101_1010
`define SEG_DIGIT_3     8'b1111_0010
`define SEG_DIGIT_4     8'b0110_0110
`define SEG_DIGIT_5     8'b1011_0110
`define SEG_DIGIT_6     8'b1011_1110
`define SEG_DIGIT_7     8'b1110_0000
`define SEG_DIGIT_8     8'b1111_1110
`define SEG_DIGIT_9     8'b1111_0110

`endif

// File: hdl/quiz_setup_pkg.sv
`include "quiz_setup_consts.svh"

package quiz_setup_pkg;

    // question kind, value doubles as the record kind field
    typedef enum logic [2:0] {
        KIND_1 = 3'd1,
        KIND_2 = 3'd2,
        KIND_3 = 3'd3,
        KIND_4 = 3'd4,
        KIND_5 = 3'd5
    } kind_t;

    typedef logic [1:0] op_idx_t;   // shown as index + 1
    typedef logic [7:0] operand_t;
    typedef logic [7:0] seg_t;

    typedef logic [$clog2(`QUESTION_DEPTH + 1) - 1:0] count_t;
    typedef logic [$clog2(`QUESTION_DEPTH) - 1:0]     addr_t;

    // stored record, 21 bits
    typedef struct packed {
        kind_t    kind;     // [20:18]
        op_idx_t  op;       // [17:16] operator code
        operand_t a;        // [15:8]
        operand_t b;        // [7:0], zero for kind 1
    } question_t;

    typedef enum logic [1:0] {
        STEP_IDLE = 2'd0,
        STEP_A    = 2'd1,
        STEP_B    = 2'd2
    } step_t;

endpackage

// File: hdl/press_tick.sv
`timescale 1ns/1ps

module press_tick #(
    parameter int tick_period = 25000000
) (
    input  logic clk,
    input  logic arst_n,
    output logic tick
);

    localparam int cnt_w = (tick_period > 1) ? $clog2(tick_period) : 1;

    logic [cnt_w-1:0] cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt == cnt_w'(tick_period - 1)) begin
            cnt  <= '0;
            tick <= 1'b1;   // one cycle pulse on wrap
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

// File: hdl/menu_ctrl.sv
`timescale 1ns/1ps
`include "quiz_setup_consts.svh"

module menu_ctrl (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    tick,
    input  logic                    setup_en,
    input  logic                    select_btn,
    input  logic                    confirm_btn,
    input  logic                    exit_btn,
    output quiz_setup_pkg::kind_t   kind,
    output quiz_setup_pkg::op_idx_t op_idx,
    output logic                    entered
);

    logic                    act;
    quiz_setup_pkg::op_idx_t op_last;

    assign act = tick & setup_en;   // buttons only count on a tick

    // highest operator index for the current kind
    always_comb begin
        case (kind)
            quiz_setup_pkg::KIND_1: op_last = quiz_setup_pkg::op_idx_t'(`OPS_KIND_1 - 1);
            quiz_setup_pkg::KIND_2: op_last = quiz_setup_pkg::op_idx_t'(`OPS_KIND_2 - 1);
            default:                op_last = quiz_setup_pkg::op_idx_t'(`OPS_OTHER - 1);
        endcase
    end

    ////////////////////
    // kind, enter flag, operator

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            kind    <= quiz_setup_pkg::KIND_1;
            op_idx  <= '0;
            entered <= 1'b0;
        end else if (act) begin
            if (!entered) begin
                if (select_btn) begin
                    if (kind == quiz_setup_pkg::kind_t'(`NUM_KINDS)) begin
                        kind <= quiz_setup_pkg::KIND_1;     // wrap 5 -> 1
                    end else begin
                        kind <= quiz_setup_pkg::kind_t'(kind + 3'd1);
                    end
                end
                if (confirm_btn) begin
                    entered <= 1'b1;
                    op_idx  <= '0;
                end
            end else if (exit_btn) begin
                entered <= 1'b0;    // exit wins over confirm
            end else if (select_btn) begin
                if (op_idx == op_last) begin
                    op_idx <= '0;
                end else begin
                    op_idx <= op_idx + 2'd1;
                end
            end
        end
    end

endmodule

// File: hdl/question_entry.sv
`timescale 1ns/1ps
`include "quiz_setup_consts.svh"

module question_entry (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      tick,
    input  logic                      setup_en,
    input  logic                      select_btn,
    input  logic                      confirm_btn,
    input  logic                      exit_btn,
    input  logic                      entered,
    input  quiz_setup_pkg::kind_t     kind,
    input  quiz_setup_pkg::op_idx_t   op_idx,
    input  quiz_setup_pkg::operand_t  switches,
    output quiz_setup_pkg::step_t     step,
    output quiz_setup_pkg::count_t    count,
    output logic                      wr_en,
    output quiz_setup_pkg::addr_t     wr_addr,
    output quiz_setup_pkg::question_t wr_data
);

    logic                     act;
    logic                     adv;
    logic                     done;
    logic                     room;
    quiz_setup_pkg::operand_t a_q;
    quiz_setup_pkg::op_idx_t  op_code;

    assign act = tick & setup_en & entered;
    assign adv = act & ~exit_btn & ~select_btn & confirm_btn;  // exit, then select first

    // record complete on confirm in A for kind 1, or in B
    assign done = adv & ((step == quiz_setup_pkg::STEP_A && kind == quiz_setup_pkg::KIND_1)
                      || step == quiz_setup_pkg::STEP_B);
    assign room    = count < quiz_setup_pkg::count_t'(`QUESTION_DEPTH);
    assign wr_en   = done & room;
    assign wr_addr = count;

    // kind 2 second operator uses code 3
    assign op_code = (kind == quiz_setup_pkg::KIND_2 && op_idx == 2'd1) ? 2'd3 : op_idx;

    always_comb begin
        wr_data.kind = kind;
        wr_data.op   = op_code;
        if (step == quiz_setup_pkg::STEP_B) begin
            wr_data.a = a_q;
            wr_data.b = switches;
        end else begin
            wr_data.a = switches;
            wr_data.b = '0;
        end
    end

    ////////////////////
    // step machine and count

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            step  <= quiz_setup_pkg::STEP_IDLE;
            count <= '0;
        end else begin
            if (act && exit_btn) begin
                step <= quiz_setup_pkg::STEP_IDLE;
            end else if (adv) begin
                case (step)
                    quiz_setup_pkg::STEP_IDLE: step <= quiz_setup_pkg::STEP_A;
                    quiz_setup_pkg::STEP_A: begin
                        if (kind == quiz_setup_pkg::KIND_1) begin
                            step <= quiz_setup_pkg::STEP_IDLE;
                        end else begin
                            step <= quiz_setup_pkg::STEP_B;
                        end
                    end
                    default: step <= quiz_setup_pkg::STEP_IDLE;
                endcase
            end
            if (wr_en) begin
                count <= count + 1'b1;  // stops at depth via room
            end
        end
    end

    // operand a held for step B
    always_ff @(posedge clk) begin
        if (adv && step == quiz_setup_pkg::STEP_A) begin
            a_q <= switches;
        end
    end

endmodule

// File: hdl/question_bank.sv
`timescale 1ns/1ps
`include "quiz_setup_consts.svh"

module question_bank (
    input  logic                      clk,
    input  logic                      wr_en,
    input  quiz_setup_pkg::addr_t     wr_addr,
    input  quiz_setup_pkg::question_t wr_data,
    input  quiz_setup_pkg::addr_t     rd_addr,
    output quiz_setup_pkg::question_t rd_data
);

    quiz_setup_pkg::question_t mem [`QUESTION_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    assign rd_data = mem[rd_addr];  // async read

endmodule

// File: hdl/seg_panel.sv
`timescale 1ns/1ps
`include "quiz_setup_consts.svh"

module seg_panel (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    entered,
    input  quiz_setup_pkg::kind_t   kind,
    input  quiz_setup_pkg::op_idx_t op_idx,
    input  quiz_setup_pkg::step_t   step,
    input  quiz_setup_pkg::count_t  count,
    output quiz_setup_pkg::seg_t    seg_kind,
    output quiz_setup_pkg::seg_t    seg_op,
    output quiz_setup_pkg::seg_t    seg_prompt_a,
    output quiz_setup_pkg::seg_t    seg_prompt_b,
    output quiz_setup_pkg::seg_t    seg_count
);

    quiz_setup_pkg::count_t count_rem;
    logic [3:0]             count_digit;

    // decimal digit to glyph
    function automatic quiz_setup_pkg::seg_t digit_glyph(input logic [3:0] digit);
        case (digit)
            4'd0:    digit_glyph = `SEG_DIGIT_0;
            4'd1:    digit_glyph = `SEG_DIGIT_1;
            4'd2:    digit_glyph = `SEG_DIGIT_2;
            4'd3:    digit_glyph = `SEG_DIGIT_3;
            4'd4:    digit_glyph = `SEG_DIGIT_4;
            4'd5:    digit_glyph = `SEG_DIGIT_5;
            4'd6:    digit_glyph = `SEG_DIGIT_6;
            4'd7:    digit_glyph = `SEG_DIGIT_7;
            4'd8:    digit_glyph = `SEG_DIGIT_8;
            4'd9:    digit_glyph = `SEG_DIGIT_9;
            default: digit_glyph = `SEG_BLANK;
        endcase
    endfunction

    assign count_rem   = count % quiz_setup_pkg::count_t'(10);
    assign count_digit = count_rem[3:0];    // last decimal digit

    ////////////////////
    // registered patterns

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            seg_kind     <= `SEG_BLANK;
            seg_op       <= `SEG_BLANK;
            seg_prompt_a <= `SEG_BLANK;
            seg_prompt_b <= `SEG_BLANK;
            seg_count    <= `SEG_BLANK;
        end else begin
            seg_kind     <= digit_glyph({1'b0, kind});
            seg_op       <= entered ? digit_glyph({2'b00, op_idx} + 4'd1) : `SEG_BLANK;
            // a prompt stays lit while b is taken
            seg_prompt_a <= (step == quiz_setup_pkg::STEP_A || step == quiz_setup_pkg::STEP_B)
                          ? `SEG_A_PROMPT : `SEG_BLANK;
            seg_prompt_b <= (step == quiz_setup_pkg::STEP_B) ? `SEG_B_PROMPT : `SEG_BLANK;
            seg_count    <= digit_glyph(count_digit);
        end
    end

endmodule

// File: hdl/quiz_setup.sv
`timescale 1ns/1ps
`include "quiz_setup_consts.svh"

module quiz_setup #(
    parameter int tick_period = `TICK_PERIOD
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      setup_en,     // menu item selected
    input  logic                      select_btn,
    input  logic                      confirm_btn,
    input  logic                      exit_btn,
    input  quiz_setup_pkg::operand_t  switches,
    input  quiz_setup_pkg::addr_t     rd_addr,
    output logic                      entered,
    output quiz_setup_pkg::kind_t     kind,
    output quiz_setup_pkg::count_t    count,
    output quiz_setup_pkg::question_t rd_data,
    output quiz_setup_pkg::seg_t      seg_kind,
    output quiz_setup_pkg::seg_t      seg_op,
    output quiz_setup_pkg::seg_t      seg_prompt_a,
    output quiz_setup_pkg::seg_t      seg_prompt_b,
    output quiz_setup_pkg::seg_t      seg_count
);

    logic                      tick;
    quiz_setup_pkg::op_idx_t   op_idx;
    quiz_setup_pkg::step_t     step;
    logic                      wr_en;
    quiz_setup_pkg::addr_t     wr_addr;
    quiz_setup_pkg::question_t wr_data;

    press_tick #(
        .tick_period (tick_period)
    ) u_press_tick (
        .clk    (clk),
        .arst_n (arst_n),
        .tick   (tick)
    );

    menu_ctrl u_menu_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .tick        (tick),
        .setup_en    (setup_en),
        .select_btn  (select_btn),
        .confirm_btn (confirm_btn),
        .exit_btn    (exit_btn),
        .kind        (kind),
        .op_idx      (op_idx),
        .entered     (entered)
    );

    question_entry u_question_entry (
        .clk         (clk),
        .arst_n      (arst_n),
        .tick        (tick),
        .setup_en    (setup_en),
        .select_btn  (select_btn),
        .confirm_btn (confirm_btn),
        .exit_btn    (exit_btn),
        .entered     (entered),
        .kind        (kind),
        .op_idx      (op_idx),
        .switches    (switches),
        .step        (step),
        .count       (count),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data)
    );

    question_bank u_question_bank (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    seg_panel u_seg_panel (
        .clk          (clk),
        .arst_n       (arst_n),
        .entered      (entered),
        .kind         (kind),
        .op_idx       (op_idx),
        .step         (step),
        .count        (count),
        .seg_kind     (seg_kind),
        .seg_op       (seg_op),
        .seg_prompt_a (seg_prompt_a),
        .seg_prompt_b (seg_prompt_b),
        .seg_count    (seg_count)
    );

endmodule

// File: verif/quiz_setup_properties.sv
`timescale 1ns/1ps
`include "quiz_setup_consts.svh"

module quiz_setup_properties (
    input logic                   clk,
    input logic                   arst_n,
    input logic                   tick,
    input logic                   entered,
    input quiz_setup_pkg::count_t count
);

    ////////////////////
    // tick pulse

    tick_single: assert property (@(posedge clk) disable iff (!arst_n) tick |=> !tick)
        else $error("tick stayed high for two cycles");

    ////////////////////
    // question count

    count_max: assert property (@(posedge clk) disable iff (!arst_n)
        count <= quiz_setup_pkg::count_t'(`QUESTION_DEPTH))
        else $error("count above bank depth");

    // only +1, and only right after a tick
    count_step: assert property (@(posedge clk) disable iff (!arst_n)
        !$stable(count) |-> (count == $past(count) + 1'b1) && $past(tick))
        else $error("count changed by other than one step after a tick");

    entered_on_tick: assert property (@(posedge clk) disable iff (!arst_n)
        !$stable(entered) |-> $past(tick))
        else $error("entered changed outside a tick");

endmodule

bind quiz_setup quiz_setup_properties u_properties (
    .clk     (clk),
    .arst_n  (arst_n),
    .tick    (tick),
    .entered (entered),
    .count   (count)
);

// File: verif/tb_quiz_setup.sv
`timescale 1ns/1ps
`include "quiz_setup_consts.svh"

module tb_quiz_setup;

    localparam int tick_period = 4;

    logic                      clk;
    logic                      arst_n;
    logic                      setup_en;
    logic                      select_btn;
    logic                      confirm_btn;
    logic                      exit_btn;
    quiz_setup_pkg::operand_t  switches;
    quiz_setup_pkg::addr_t     rd_addr;
    logic                      entered;
    quiz_setup_pkg::kind_t     kind;
    quiz_setup_pkg::count_t    count;
    quiz_setup_pkg::question_t rd_data;
    quiz_setup_pkg::seg_t      seg_kind;
    quiz_setup_pkg::seg_t      seg_op;
    quiz_setup_pkg::seg_t      seg_prompt_a;
    quiz_setup_pkg::seg_t      seg_prompt_b;
    quiz_setup_pkg::seg_t      seg_count;

    // reference model state
    int                        m_kind;
    int                        m_op;
    int                        m_step;     // 0 idle, 1 a, 2 b
    logic                      m_entered;
    quiz_setup_pkg::operand_t  m_a;
    int                        m_count;
    quiz_setup_pkg::question_t m_bank [`QUESTION_DEPTH];
    quiz_setup_pkg::seg_t      glyph_tab [10];

    int          checks;
    int          errors;
    int          test_err0;
    integer      seed;
    logic [31:0] r;
    int          i;
    int          j;
    int          k;
    int          extra;
    int          saved;

    quiz_setup #(
        .tick_period (tick_period)
    ) uut (
        .clk          (clk),
        .arst_n       (arst_n),
        .setup_en     (setup_en),
        .select_btn   (select_btn),
        .confirm_btn  (confirm_btn),
        .exit_btn     (exit_btn),
        .switches     (switches),
        .rd_addr      (rd_addr),
        .entered      (entered),
        .kind         (kind),
        .count        (count),
        .rd_data      (rd_data),
        .seg_kind     (seg_kind),
        .seg_op       (seg_op),
        .seg_prompt_a (seg_prompt_a),
        .seg_prompt_b (seg_prompt_b),
        .seg_count    (seg_count)
    );

    always #4 clk = ~clk;

    ////////////////////
    // compare tasks

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_kind(input quiz_setup_pkg::kind_t got,
                              input quiz_setup_pkg::kind_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input quiz_setup_pkg::count_t got,
                               input quiz_setup_pkg::count_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_seg(input quiz_setup_pkg::seg_t got,
                             input quiz_setup_pkg::seg_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s shows %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_question(input quiz_setup_pkg::question_t got,
                                  input quiz_setup_pkg::question_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    ////////////////////
    // reference model

    function automatic int op_count(input int kd);
        op_count = (kd == 1) ? 3 : (kd == 2) ? 2 : 4;
    endfunction

    function automatic quiz_setup_pkg::question_t make_record(input int kd, input int code,
        input quiz_setup_pkg::operand_t a, input quiz_setup_pkg::operand_t b);
        logic [20:0] raw;
        raw = {kd[2:0], code[1:0], a, b};   // kind, op code, a, b
        make_record = quiz_setup_pkg::question_t'(raw);
    endfunction

    task automatic store_record(input quiz_setup_pkg::question_t rec);
        if (m_count < `QUESTION_DEPTH) begin
            m_bank[m_count] = rec;
            m_count++;
        end
    endtask

    task automatic model_step(input logic sel, input logic conf, input logic ext,
                              input logic en, input quiz_setup_pkg::operand_t sw);
        int code;
        code = (m_kind == 2 && m_op == 1) ? 3 : m_op;
        if (en && !m_entered) begin
            if (sel) begin
                m_kind = (m_kind == `NUM_KINDS) ? 1 : m_kind + 1;
            end
            if (conf) begin
                m_entered = 1'b1;
                m_op      = 0;
            end
        end else if (en && ext) begin
            m_entered = 1'b0;
            m_step    = 0;
        end else if (en && sel) begin
            m_op = (m_op + 1) % op_count(m_kind);
        end else if (en && conf) begin
            case (m_step)
                0: m_step = 1;
                1: begin
                    if (m_kind == 1) begin
                        store_record(make_record(m_kind, code, sw, 8'h00));
                        m_step = 0;
                    end else begin
                        m_a    = sw;
                        m_step = 2;
                    end
                end
                default: begin
                    store_record(make_record(m_kind, code, m_a, sw));
                    m_step = 0;
                end
            endcase
        end
    endtask

    task automatic check_state();
        check_flag(entered, m_entered, "entered");
        check_kind(kind, quiz_setup_pkg::kind_t'(m_kind[2:0]), "kind");
        check_count(count, quiz_setup_pkg::count_t'(m_count), "count");
        check_seg(seg_kind, glyph_tab[m_kind], "kind digit");
        check_seg(seg_op, m_entered ? glyph_tab[m_op + 1] : `SEG_BLANK, "operator digit");
        check_seg(seg_prompt_a, (m_step != 0) ? `SEG_A_PROMPT : `SEG_BLANK, "a prompt");
        check_seg(seg_prompt_b, (m_step == 2) ? `SEG_B_PROMPT : `SEG_BLANK, "b prompt");
        check_seg(seg_count, glyph_tab[m_count % 10], "count digit");
    endtask

    ////////////////////
    // stimulus

    // one window of tick_period cycles, must hold exactly one tick
    task automatic hold_window(input string what);
        int ticks;
        int n;
        ticks = 0;
        for (n = 0; n < tick_period; n++) begin
            if (uut.tick === 1'b1) ticks++;
            @(negedge clk);
        end
        if (ticks != 1) begin
            errors++;
            $display("%0d ticks seen in a %s window instead of exactly one", ticks, what);
        end
    endtask

    task automatic press(input logic sel, input logic conf, input logic ext,
                         input logic en, input quiz_setup_pkg::operand_t sw);
        select_btn  = sel;
        confirm_btn = conf;
        exit_btn    = ext;
        setup_en    = en;
        switches    = sw;
        hold_window("button");
        select_btn  = 1'b0;
        confirm_btn = 1'b0;
        exit_btn    = 1'b0;
        hold_window("settle");      // panel lags state by one cycle
        model_step(sel, conf, ext, en, sw);
        check_state();
    endtask

    task automatic check_bank(input int idx, input quiz_setup_pkg::question_t exp);
        rd_addr = quiz_setup_pkg::addr_t'(idx);
        @(negedge clk);
        check_question(rd_data, exp, $sformatf("record %0d", idx));
    endtask

    task automatic wait_panel_ready();
        int n;
        n = 0;
        while (seg_kind === `SEG_BLANK && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (seg_kind === `SEG_BLANK) begin
            errors++;
            $display("timeout: the panel stayed blank after reset");
        end
    endtask

    task automatic end_test(input string name);
        if (errors == test_err0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_err0);
        end
        test_err0 = errors;
    endtask

    initial begin
        seed         = 32'ha60b;
        glyph_tab[0] = `SEG_DIGIT_0;
        glyph_tab[1] = `SEG_DIGIT_1;
        glyph_tab[2] = `SEG_DIGIT_2;
        glyph_tab[3] = `SEG_DIGIT_3;
        glyph_tab[4] = `SEG_DIGIT_4;
        glyph_tab[5] = `SEG_DIGIT_5;
        glyph_tab[6] = `SEG_DIGIT_6;
        glyph_tab[7] = `SEG_DIGIT_7;
        glyph_tab[8] = `SEG_DIGIT_8;
        glyph_tab[9] = `SEG_DIGIT_9;
        clk = 1'b0;
        arst_n = 1'b0;
        setup_en = 1'b0;
        select_btn = 1'b0;
        confirm_btn = 1'b0;
        exit_btn = 1'b0;
        switches = '0;
        rd_addr = '0;
        m_kind = 1;
        m_op = 0;
        m_step = 0;
        m_entered = 1'b0;
        m_a = '0;
        m_count = 0;
        checks = 0;
        errors = 0;
        test_err0 = 0;
        repeat (5) @(negedge clk);
        check_seg(seg_kind, `SEG_BLANK, "kind digit in reset");
        check_seg(seg_count, `SEG_BLANK, "count digit in reset");
        arst_n = 1'b1;

        // 1: reset values, kind wrap
        wait_panel_ready();
        check_flag(entered, 1'b0, "entered after reset");
        check_count(count, '0, "count after reset");
        check_seg(seg_kind, glyph_tab[1], "kind digit after reset");
        repeat (6) press(1'b1, 1'b0, 1'b0, 1'b1, 8'h00);    // 2 3 4 5 1 2
        end_test("1 reset and kind select");

        // 2: operator wrap per kind
        repeat (4) press(1'b1, 1'b0, 1'b0, 1'b1, 8'h00);    // back to kind 1
        for (k = 1; k <= `NUM_KINDS; k++) begin
            press(1'b0, 1'b1, 1'b0, 1'b1, 8'h00);
            for (j = 0; j <= op_count(k); j++) begin
                press(1'b1, 1'b0, 1'b0, 1'b1, 8'h00);
            end
            press(1'b0, 1'b0, 1'b1, 1'b1, 8'h00);
            check_seg(seg_op, `SEG_BLANK, "operator digit after exit");
            press(1'b1, 1'b0, 1'b0, 1'b1, 8'h00);
        end
        end_test("2 operator cycling");

        // 3: kind 1 record, kind 2 code 3 record
        press(1'b0, 1'b1, 1'b0, 1'b1, 8'h00);
        press(1'b1, 1'b0, 1'b0, 1'b1, 8'h00);
        press(1'b0, 1'b1, 1'b0, 1'b1, 8'h00);
        press(1'b0, 1'b1, 1'b0, 1'b1, 8'h5a);
        check_bank(0, make_record(1, 1, 8'h5a, 8'h00));
        press(1'b0, 1'b0, 1'b1, 1'b1, 8'h00);
        press(1'b1, 1'b0, 1'b0, 1'b1, 8'h00);
        press(1'b0, 1'b1, 1'b0, 1'b1, 8'h00);
        press(1'b1, 1'b0, 1'b0, 1'b1, 8'h00);
        press(1'b0, 1'b1, 1'b0, 1'b1, 8'h00);
        press(1'b0, 1'b1, 1'b0, 1'b1, 8'h33);
        press(1'b0, 1'b1, 1'b0, 1'b1, 8'hc4);
        check_bank(1, make_record(2, 3, 8'h33, 8'hc4));
        end_test("3 record layout");

        // 4: prompts, then exit from step b
        press(1'b0, 1'b1, 1'b0, 1'b1, 8'h00);
        press(1'b0, 1'b1, 1'b0, 1'b1, 8'h77);
        saved = m_count;
        press(1'b0, 1'b0, 1'b1, 1'b1, 8'h99);
        check_count(count, quiz_setup_pkg::count_t'(saved), "count after exit in step b");
        end_test("4 prompts and exit");

        // 5: nothing moves while not selected
        press(1'b0, 1'b1, 1'b0, 1'b1, 8'h00);
        press(1'b0, 1'b1, 1'b0, 1'b1, 8'h00);
        for (i = 0; i < 24; i++) begin
            r = $random(seed);
            press(r[0], r[1], r[2], 1'b0, r[15:8]);
        end
        end_test("5 setup_en low");

        // 6: random run until the bank is full, then some more
        extra = 0;
        for (i = 0; i < 3000 && extra < 60; i++) begin
            r = $random(seed);
            press(r[1:0] == 2'd0, r[3:2] != 2'd0, r[7:4] == 4'd0, r[10:8] != 3'd0, r[23:16]);
            if (m_count == `QUESTION_DEPTH) extra++;
        end
        if (m_count != `QUESTION_DEPTH) begin
            errors++;
            $display("the random run ended before the bank was full");
        end
        check_count(count, quiz_setup_pkg::count_t'(`QUESTION_DEPTH), "count after fill");
        for (i = 0; i < `QUESTION_DEPTH; i++) begin
            check_bank(i, m_bank[i]);
        end
        end_test("6 random fill");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: quiz_setup.f
+incdir+hdl
hdl/quiz_setup_pkg.sv
hdl/press_tick.sv
hdl/menu_ctrl.sv
hdl/question_entry.sv
hdl/question_bank.sv
hdl/seg_panel.sv
hdl/quiz_setup.sv
verif/quiz_setup_properties.sv
verif/tb_quiz_setup.sv
